//--- all.f
verilog/synctimer_pkg.sv
verilog/byte_stream_if.sv
verilog/synctimer_frame_monitor.sv
verilog/synctimer_request_parser.sv
verilog/synctimer_local_clock.sv
verilog/synctimer_slave_top.sv
verification/synctimer_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the sync timer slave testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module synctimer_slave_tb \
    -Mdir obj_dir \
    -f all.f

status=0
output=$(./obj_dir/Vsynctimer_slave_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

//--- verification/synctimer_slave_tb.sv
// testbench for the sync timer slave: frame table, frame builder, reference model, watchdog
`default_nettype none
`timescale 1ns/1ns

module synctimer_slave_tb import synctimer_pkg::*; ();

    localparam int TIME_STEP    = 4;
    localparam int ADJUST_SHIFT = 2;
    localparam int no_error     = -1;
    // command, time, offset and the byte at counter value 10
    localparam int max_forward  = 12;
    localparam int pipe_latency = 3;
    localparam int table_size   = 7;

    typedef struct {
        byte_t   cmd;
        time_t   rx_time;
        offset_t offset;
        int      length;
        int      error_index;
        bit      expect_correction;
    } frame_entry_t;

    frame_entry_t frame_table [table_size];

    logic  clk = 1'b0;
    logic  local_reset;
    logic  in_first;
    logic  in_last;
    logic  in_valid;
    logic  in_error;
    byte_t in_data;
    logic  out_first;
    logic  out_last;
    logic  out_valid;
    byte_t out_data;
    time_t now_time;
    logic  time_corrected;
    logic  time_override;

    int    seed = 90;
    int    cycle_count = 0;
    int    correction_count = 0;
    bit    time_known = 1'b0;
    time_t next_time;
    bit    exp_override;
    time_t exp_corr_time;

    byte_t frame_bytes[$];
    int    drive_cycles[$];
    byte_t got_data[$];
    bit    got_first[$];
    bit    got_last[$];
    int    got_cycle[$];

    synctimer_slave_top #(
        .TIME_STEP    (TIME_STEP),
        .ADJUST_SHIFT (ADJUST_SHIFT)
    ) synctimer_slave_top_inst (
        .clk            (clk),
        .local_reset    (local_reset),
        .in_first       (in_first),
        .in_last        (in_last),
        .in_valid       (in_valid),
        .in_error       (in_error),
        .in_data        (in_data),
        .out_first      (out_first),
        .out_last       (out_last),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .now_time       (now_time),
        .time_corrected (time_corrected),
        .time_override  (time_override)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ########################################################################
    // helpers
    // ########################################################################

    task automatic check_value(input string name, input time_t actual, input time_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic load_table();
        // override, then adjust with the master ahead and behind
        frame_table[0] = '{8'h01, 64'h0000_0012_3456_7000, 16'h0010, 11, no_error, 1'b1};
        frame_table[1] = '{8'h02, 64'h0000_0012_3456_7800, 16'h0100, 11, no_error, 1'b1};
        frame_table[2] = '{8'h04, 64'h0000_0000_0000_1000, 16'h0020, 11, no_error, 1'b1};
        // aborted frames
        frame_table[3] = '{8'h01, 64'h0000_00ab_cdef_0000, 16'h0040, 11, 5, 1'b0};
        frame_table[4] = '{8'h10, 64'h0000_0001_0000_0000, 16'h0008, 11, 10, 1'b0};
        // too long, truncated after 12 bytes
        frame_table[5] = '{8'h03, 64'h0000_0034_0000_1234, 16'hff00, 15, no_error, 1'b1};
        frame_table[6] = '{8'h00, 64'h0000_0034_0000_2000, 16'h0004, 11, no_error, 1'b1};
    endtask

    task automatic build_frame(input frame_entry_t entry);
        frame_bytes.delete();
        frame_bytes.push_back(entry.cmd);
        for (int i = 0; i < time_field_bytes; i++) begin
            frame_bytes.push_back(entry.rx_time[i*8 +: 8]);
        end
        for (int i = 0; i < offset_field_bytes; i++) begin
            frame_bytes.push_back(entry.offset[i*8 +: 8]);
        end
        // filler past the offset field
        while (frame_bytes.size() < entry.length) begin
            frame_bytes.push_back(byte_t'(8'ha0 + frame_bytes.size()));
        end
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        in_error = 1'b0;
        in_data  = '0;
    endtask

    task automatic drive_frame(input frame_entry_t entry);
        drive_cycles.delete();
        for (int i = 0; i < frame_bytes.size(); i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_first = (i == 0);
            in_last  = (i == frame_bytes.size() - 1);
            in_error = (i == entry.error_index);
            in_data  = frame_bytes[i];
            drive_cycles.push_back(cycle_count);
        end
        @(posedge clk);
        #1;
        drive_idle();
    endtask

    task automatic check_forwarding(input frame_entry_t entry);
        int    expected_count;
        byte_t expected_byte;
        expected_count = (entry.length < max_forward) ? entry.length : max_forward;
        if (entry.error_index != no_error && entry.error_index < expected_count) begin
            expected_count = entry.error_index;
        end
        check_value("forwarded byte count", time_t'(got_data.size()), time_t'(expected_count));
        for (int i = 0; i < expected_count; i++) begin
            expected_byte = (i == 0) ? byte_t'(frame_bytes[0] + 8'd1) : frame_bytes[i];
            check_value("out_data", time_t'(got_data[i]), time_t'(expected_byte));
            check_value("out_first", time_t'(got_first[i]), time_t'(i == 0));
            check_value("out_last", time_t'(got_last[i]), time_t'(i == entry.length - 1));
            check_value("forwarding latency", time_t'(got_cycle[i] - drive_cycles[i]),
                        time_t'(pipe_latency));
        end
        got_data.delete();
        got_first.delete();
        got_last.delete();
        got_cycle.delete();
    endtask

    // ########################################################################
    // reference model for now_time and output collection
    // ########################################################################

    always @(negedge clk) begin
        logic signed [63:0] time_error;
        if (time_known) begin
            check_value("now_time", now_time, next_time);
        end
        if (local_reset) begin
            next_time  = '0;
            time_known = 1'b1;
        end else if (time_corrected) begin
            correction_count++;
            check_value("time_override", time_t'(time_override), time_t'(exp_override));
            if (exp_override) begin
                next_time = exp_corr_time;
            end else begin
                time_error = $signed(exp_corr_time - now_time);
                next_time  = now_time + time_t'(TIME_STEP) + time_t'(time_error >>> ADJUST_SHIFT);
            end
        end else begin
            next_time = now_time + time_t'(TIME_STEP);
        end
        if (out_valid) begin
            got_data.push_back(out_data);
            got_first.push_back(out_first);
            got_last.push_back(out_last);
            got_cycle.push_back(cycle_count);
        end
    end

    // ########################################################################
    // main sequence and watchdog
    // ########################################################################

    initial begin
        int count_before;
        int gap;
        load_table();
        drive_idle();
        local_reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        local_reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", time_t'(out_valid), '0);
            check_value("time_corrected", time_t'(time_corrected), '0);
        end
        for (int n = 0; n < table_size; n++) begin
            build_frame(frame_table[n]);
            exp_override  = frame_table[n].cmd[cmd_override_bit];
            exp_corr_time = frame_table[n].rx_time + time_t'(frame_table[n].offset);
            count_before  = correction_count;
            drive_frame(frame_table[n]);
            if (frame_table[n].expect_correction) begin
                while (correction_count == count_before) begin
                    @(posedge clk);
                end
                @(posedge clk);
            end else begin
                // longer than the last byte to load latency
                repeat (8) @(posedge clk);
            end
            check_value("correction count", time_t'(correction_count - count_before),
                        time_t'(frame_table[n].expect_correction));
            check_forwarding(frame_table[n]);
            gap = 2 + ($random(seed) & 7);
            repeat (gap) @(posedge clk);
        end
        $display("Test passed");
        $finish;
    end

    initial begin
        repeat (table_size * 64) @(posedge clk);
        $display("Timeout: frame table not finished after %0d cycles", table_size * 64);
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- verilog/byte_stream_if.sv
// byte stream interface with first/last/data/valid and source/sink modports
`default_nettype none
`timescale 1ns/1ns

interface byte_stream_if import synctimer_pkg::*; ();

    // first and last only qualify bytes with valid high
    logic  first;
    logic  last;
    byte_t data;
    logic  valid;

    modport source (
        output first,
        output last,
        output data,
        output valid
    );

    modport sink (
        input first,
        input last,
        input data,
        input valid
    );

endinterface

`default_nettype wire

//--- verilog/synctimer_frame_monitor.sv
// frame monitor: two-stage stream delay with start, end and error events
`default_nettype none
`timescale 1ns/1ns

module synctimer_frame_monitor import synctimer_pkg::*; (
    input  logic   clk,
    input  logic   local_reset,
    input  logic   in_first,
    input  logic   in_last,
    input  logic   in_valid,
    input  logic   in_error,
    input  byte_t  in_data,
    byte_stream_if.source m,
    output logic   rx_start,
    output logic   rx_end,
    output logic   rx_error
);

    logic  in_frame;
    logic  end_ok;

    // first delay stage
    logic  stage_first;
    logic  stage_last;
    byte_t stage_data;
    logic  stage_valid;
    logic  stage_end_ok;
    logic  out_end_ok;

    // only a clean last byte of a tracked frame may close it with an end event
    assign end_ok = in_valid && in_last && !in_error && (in_frame || in_first);

    // ########################################################################
    // frame tracking and events
    // ########################################################################

    always_ff @(posedge clk) begin
        if (local_reset) begin
            in_frame <= 1'b0;
            rx_start <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_start <= in_valid && in_first;
            // phy error, or a new first while the old frame is still open
            rx_error <= in_valid && (in_error || (in_first && in_frame));

            if (in_valid) begin
                if (in_error) begin
                    in_frame <= 1'b0;
                end else if (in_first) begin
                    in_frame <= !in_last;
                end else if (in_last) begin
                    in_frame <= 1'b0;
                end
            end
        end
    end

    // ########################################################################
    // stream delay
    // ########################################################################

    always_ff @(posedge clk) begin
        stage_first <= in_first;
        stage_last  <= in_last;
        stage_data  <= in_data;
        m.first     <= stage_first;
        m.last      <= stage_last;
        m.data      <= stage_data;
    end

    always_ff @(posedge clk) begin
        if (local_reset) begin
            stage_valid  <= 1'b0;
            stage_end_ok <= 1'b0;
            m.valid      <= 1'b0;
            out_end_ok   <= 1'b0;
            rx_end       <= 1'b0;
        end else begin
            stage_valid  <= in_valid;
            stage_end_ok <= end_ok;
            m.valid      <= stage_valid;
            out_end_ok   <= stage_end_ok;
            // one cycle after the delayed last byte
            rx_end       <= out_end_ok;
        end
    end

endmodule

`default_nettype wire

//--- verilog/synctimer_local_clock.sv
// local time counter with override load and proportional slew
`default_nettype none
`timescale 1ns/1ns

module synctimer_local_clock import synctimer_pkg::*; #(
    parameter int TIME_STEP    = 4,
    parameter int ADJUST_SHIFT = 2
) (
    input  logic  clk,
    input  logic  local_reset,
    input  logic  correct_override,
    input  time_t correct_time,
    input  logic  correct_valid,
    output time_t now_time
);

    localparam time_t step = time_t'(TIME_STEP);

    logic signed [$bits(time_t)-1:0] time_error;
    logic signed [$bits(time_t)-1:0] slew;

    // positive when the master is ahead of us
    assign time_error = signed'(correct_time - now_time);
    assign slew       = time_error >>> ADJUST_SHIFT;

    // ########################################################################
    // counter
    // ########################################################################

    always_ff @(posedge clk) begin
        if (local_reset) begin
            now_time <= '0;
        end else begin
            if (correct_valid) begin
                if (correct_override) begin
                    now_time <= correct_time;
                end else begin
                    // take a fraction of the error per correction
                    now_time <= now_time + step + time_t'(slew);
                end
            end else begin
                now_time <= now_time + step;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/synctimer_pkg.sv
// time, offset, byte and command types, frame field layout
`default_nettype none

package synctimer_pkg;

    // ########################################################################
    // types
    // ########################################################################

    // nanoseconds
    typedef logic [63:0] time_t;

    // added to the received time before correction
    typedef logic [15:0] offset_t;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] cmd_t;

    // ########################################################################
    // frame layout
    // ########################################################################

    // set means load the clock, clear means slew it
    localparam int cmd_override_bit = 0;

    // field lengths after the command byte, both little-endian
    localparam int time_field_bytes   = 8;
    localparam int offset_field_bytes = 2;

endpackage

`default_nettype wire

//--- verilog/synctimer_request_parser.sv
// request parser: field capture, forwarding with incremented command, correction
`default_nettype none
`timescale 1ns/1ns

module synctimer_request_parser import synctimer_pkg::*; (
    input  logic  clk,
    input  logic  local_reset,
    input  logic  rx_start,
    input  logic  rx_end,
    input  logic  rx_error,
    byte_stream_if.sink   s,
    byte_stream_if.source m,
    output logic  correct_override,
    output time_t correct_time,
    output logic  correct_valid
);

    // counter value of the first byte past the offset field
    localparam int field_end = time_field_bytes + offset_field_bytes;

    logic       frame_reset;
    logic       busy;
    logic [3:0] byte_count;

    cmd_t    rx_cmd;
    time_t   rx_time;
    offset_t rx_offset;

    assign frame_reset = local_reset || rx_error;

    // ########################################################################
    // capture control
    // ########################################################################

    always_ff @(posedge clk) begin
        if (frame_reset) begin
            busy       <= 1'b0;
            byte_count <= '0;
        end else begin
            if (s.valid) begin
                byte_count <= byte_count + 1'b1;
                if (!busy) begin
                    if (s.first) begin
                        busy       <= 1'b1;
                        byte_count <= '0;
                    end
                end else begin
                    // the byte at field_end is still forwarded
                    if (int'(byte_count) >= field_end) begin
                        busy <= 1'b0;
                    end
                    if (s.last) begin
                        busy <= 1'b0;
                    end
                end
            end
            if (rx_start || rx_end || rx_error) begin
                busy <= 1'b0;
            end
        end
    end

    // field registers
    always_ff @(posedge clk) begin
        if (s.valid) begin
            if (!busy && s.first) begin
                rx_cmd <= s.data;
            end else if (busy) begin
                if (int'(byte_count) < time_field_bytes) begin
                    rx_time[byte_count[2:0]*8 +: 8] <= s.data;
                end else if (int'(byte_count) < field_end) begin
                    // offset bytes sit at counts 8 and 9
                    rx_offset[byte_count[0]*8 +: 8] <= s.data;
                end
            end
        end
    end

    // ########################################################################
    // forwarding
    // ########################################################################

    always_ff @(posedge clk) begin
        m.first <= s.first;
        m.last  <= s.last;
        if (!busy && s.first) begin
            // next node sees the command bumped by one
            m.data <= s.data + 1'b1;
        end else begin
            m.data <= s.data;
        end
    end

    always_ff @(posedge clk) begin
        if (local_reset) begin
            m.valid <= 1'b0;
        end else begin
            m.valid <= s.valid && (busy || s.first);
        end
    end

    // ########################################################################
    // correction
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rx_end) begin
            correct_time <= rx_time + time_t'(rx_offset);
        end
    end

    always_ff @(posedge clk) begin
        if (local_reset) begin
            correct_valid    <= 1'b0;
            correct_override <= 1'b0;
        end else begin
            correct_valid <= rx_end;
            if (rx_end) begin
                correct_override <= rx_cmd[cmd_override_bit];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/synctimer_slave_top.sv
// sync timer slave top: frame monitor, request parser and local clock
`default_nettype none
`timescale 1ns/1ns

module synctimer_slave_top import synctimer_pkg::*; #(
    parameter int TIME_STEP    = 4,
    parameter int ADJUST_SHIFT = 2
) (
    input  logic  clk,
    input  logic  local_reset,

    input  logic  in_first,
    input  logic  in_last,
    input  logic  in_valid,
    input  logic  in_error,
    input  byte_t in_data,

    output logic  out_first,
    output logic  out_last,
    output logic  out_valid,
    output byte_t out_data,

    output time_t now_time,
    output logic  time_corrected,
    output logic  time_override
);

    logic  rx_start;
    logic  rx_end;
    logic  rx_error;
    time_t correct_time;

    byte_stream_if monitor_to_parser ();
    byte_stream_if parser_out ();

    // ########################################################################
    // receive path
    // ########################################################################

    synctimer_frame_monitor synctimer_frame_monitor_inst (
        .clk         (clk),
        .local_reset (local_reset),
        .in_first    (in_first),
        .in_last     (in_last),
        .in_valid    (in_valid),
        .in_error    (in_error),
        .in_data     (in_data),
        .m           (monitor_to_parser.source),
        .rx_start    (rx_start),
        .rx_end      (rx_end),
        .rx_error    (rx_error)
    );

    synctimer_request_parser synctimer_request_parser_inst (
        .clk              (clk),
        .local_reset      (local_reset),
        .rx_start         (rx_start),
        .rx_end           (rx_end),
        .rx_error         (rx_error),
        .s                (monitor_to_parser.sink),
        .m                (parser_out.source),
        .correct_override (time_override),
        .correct_time     (correct_time),
        .correct_valid    (time_corrected)
    );

    assign out_first = parser_out.first;
    assign out_last  = parser_out.last;
    assign out_valid = parser_out.valid;
    assign out_data  = parser_out.data;

    // ########################################################################
    // time base
    // ########################################################################

    synctimer_local_clock #(
        .TIME_STEP    (TIME_STEP),
        .ADJUST_SHIFT (ADJUST_SHIFT)
    ) synctimer_local_clock_inst (
        .clk              (clk),
        .local_reset      (local_reset),
        .correct_override (time_override),
        .correct_time     (correct_time),
        .correct_valid    (time_corrected),
        .now_time         (now_time)
    );

endmodule

`default_nettype wire
